//--- source/SdramCtrl_defines.svh
// SDRAM controller constants: pin command codes, initialisation timing and mode word
`ifndef SDRAMCTRL_DEFINES_SVH
`define SDRAMCTRL_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// pin commands, bit order {CKE, CS_L, RAS_L, CAS_L, WE_L}
//////////////////////////////////////////////////////////////////////

`define SDRAM_CMD_POWERUP      5'b00000    // cke and cs low while the part powers up
`define SDRAM_CMD_NOP          5'b10111    // clock enabled, no operation
`define SDRAM_CMD_PRECHARGE    5'b10010    // precharge, a10 picks all banks
`define SDRAM_CMD_REFRESH      5'b10001    // auto-refresh
`define SDRAM_CMD_MODESET      5'b10000    // load mode register from address bus

//////////////////////////////////////////////////////////////////////
// timing counts in controller clocks
//////////////////////////////////////////////////////////////////////

`define SDRAM_POWERUP_CYCLES   16'd8       // short power-up wait for simulation
`define SDRAM_INIT_REFRESHES   4'd2        // auto-refreshes during initialisation
`define SDRAM_REFRESH_GAP      4'd3        // nop cycles after each auto-refresh
`define SDRAM_REFRESH_INTERVAL 16'd38      // idle cycles between run-mode refreshes

//////////////////////////////////////////////////////////////////////
// address bus values
//////////////////////////////////////////////////////////////////////

// burst length 1, sequential, CAS latency 2, single location writes
`define SDRAM_MODE_VALUE         13'h0220  // mode register word
`define SDRAM_PRECHARGE_ALL_ADDR 13'h0400  // a10 high selects all banks

`endif

//--- source/SdramPkg.sv
// SDRAM controller types: bus widths and the state encodings of both command peers
package SdramPkg;

	//////////////////////////////////////////////////////////////////////
	// bus widths for a 32M x16 part
	//////////////////////////////////////////////////////////////////////

	typedef logic [4:0]  sdramCmd_t;   // {cke, cs_l, ras_l, cas_l, we_l}
	typedef logic [12:0] rowAddr_t;    // 13 bit row / mode address
	typedef logic [1:0]  bankAddr_t;   // 4 banks
	typedef logic [15:0] tickCount_t;  // general purpose timer count

	//////////////////////////////////////////////////////////////////////
	// power-up sequencer states
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		initPowerWait,                 // cke low, waiting out power-up time
		initFirstNop,                  // first valid nop with cke high
		initPrecharge,                 // precharge all banks
		initRefresh,                   // one auto-refresh of the init loop
		initGap,                       // nops after each auto-refresh
		initModeLoad,                  // mode register set
		initComplete                   // sequence over, bus released
	} initState_t;

	//////////////////////////////////////////////////////////////////////
	// refresh scheduler states
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		refIdle,                       // interval timer running
		refPrecharge,                  // close all banks before refresh
		refNop,                        // one nop after precharge
		refAuto,                       // auto-refresh
		refGap                         // trailing nops
	} refreshState_t;

endpackage

//--- source/PowerUpSequencer.sv
// Power-up sequencer: issues the SDRAM initialisation commands and then releases the CPU
`include "SdramCtrl_defines.svh"

module PowerUpSequencer (
	input  logic                 Clock,
	input  logic                 Reset_L,
	input  logic                 initGrant,   // arbiter has given us the pins
	output logic                 initReq,     // held until mode load is presented
	output SdramPkg::sdramCmd_t  initCmd,
	output SdramPkg::rowAddr_t   initAddr,
	output SdramPkg::bankAddr_t  initBank,
	output logic                 initDone,    // tells the refresh scheduler to start
	output logic                 ResetOut_L   // reset to the CPU
);

	SdramPkg::initState_t  state;
	SdramPkg::tickCount_t  waitCount;            // power-up wait down-counter
	logic [3:0]            refreshLeft;          // init auto-refreshes still to issue
	logic [3:0]            gapLeft;              // gap nops still to issue

	//////////////////////////////////////////////////////////////////////
	// sequence state machine
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state       <= SdramPkg::initPowerWait;
			waitCount   <= `SDRAM_POWERUP_CYCLES;
			refreshLeft <= `SDRAM_INIT_REFRESHES;
			gapLeft     <= 4'd0;
			initReq     <= 1'b0;
		end else begin
			if (waitCount != 16'd0)              // free running until it hits zero
				waitCount <= waitCount - 16'd1;

			// request from reset, drop once the mode load has gone out
			initReq <= (state != SdramPkg::initComplete) &&
				!(state == SdramPkg::initModeLoad && initGrant);

			if (initGrant) begin                 // steps only move while granted
				case (state)
					SdramPkg::initPowerWait: begin
						if (waitCount == 16'd0)  // power-up time elapsed
							state <= SdramPkg::initFirstNop;
					end
					SdramPkg::initFirstNop: begin
						state <= SdramPkg::initPrecharge;
					end
					SdramPkg::initPrecharge: begin
						state <= SdramPkg::initRefresh;
					end
					SdramPkg::initRefresh: begin
						refreshLeft <= refreshLeft - 4'd1;
						gapLeft     <= `SDRAM_REFRESH_GAP - 4'd1;
						state       <= SdramPkg::initGap;
					end
					SdramPkg::initGap: begin
						if (gapLeft != 4'd0)
							gapLeft <= gapLeft - 4'd1;
						else if (refreshLeft != 4'd0)
							state <= SdramPkg::initRefresh;     // next loop pass
						else
							state <= SdramPkg::initModeLoad;    // loop finished
					end
					SdramPkg::initModeLoad: begin
						state <= SdramPkg::initComplete;
					end
					default: begin
						state <= SdramPkg::initComplete;        // park here until reset
					end
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// done flag and CPU reset release
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			initDone   <= 1'b0;
			ResetOut_L <= 1'b0;              // CPU held in reset
		end else if (state == SdramPkg::initComplete) begin
			initDone   <= 1'b1;              // sticky until next reset
			ResetOut_L <= 1'b1;
		end
	end

	// command decode from state
	always_comb begin
		initCmd  = `SDRAM_CMD_NOP;               // most steps are nops
		initAddr = 13'h0000;
		initBank = 2'b00;                        // mode load needs bank 0
		case (state)
			SdramPkg::initPowerWait: initCmd = `SDRAM_CMD_POWERUP;
			SdramPkg::initPrecharge: begin
				initCmd  = `SDRAM_CMD_PRECHARGE;
				initAddr = `SDRAM_PRECHARGE_ALL_ADDR;
			end
			SdramPkg::initRefresh:   initCmd = `SDRAM_CMD_REFRESH;
			SdramPkg::initModeLoad: begin
				initCmd  = `SDRAM_CMD_MODESET;
				initAddr = `SDRAM_MODE_VALUE;    // cas latency 2
			end
			default:                 initCmd = `SDRAM_CMD_NOP;
		endcase
	end

endmodule

//--- source/RefreshScheduler.sv
// Refresh scheduler: times the refresh interval and runs the precharge and auto-refresh steps
`include "SdramCtrl_defines.svh"

module RefreshScheduler (
	input  logic                 Clock,
	input  logic                 Reset_L,
	input  logic                 initDone,    // initialisation finished
	input  logic                 refGrant,
	output logic                 refReq,
	output SdramPkg::sdramCmd_t  refCmd,
	output SdramPkg::rowAddr_t   refAddr,
	output SdramPkg::bankAddr_t  refBank
);

	SdramPkg::refreshState_t  state;
	SdramPkg::tickCount_t     interval;          // counts down to next refresh
	logic [3:0]               gapLeft;           // trailing nops still to issue
	logic                     initDoneQ;         // for the rising edge of initDone
	logic                     seqEnd;            // last gap nop presented
	logic                     loadInterval;
	logic                     expired;

	assign seqEnd       = (state == SdramPkg::refGap) && refGrant && (gapLeft == 4'd0);
	assign loadInterval = (initDone && !initDoneQ) || seqEnd;
	assign expired      = initDone && !loadInterval && (interval == 16'd0) &&
		(state == SdramPkg::refIdle);
	assign refReq       = (state != SdramPkg::refIdle);   // held for the whole sequence

	//////////////////////////////////////////////////////////////////////
	// interval timer, stopped until initDone
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			initDoneQ <= 1'b0;
			interval  <= 16'd0;
		end else begin
			initDoneQ <= initDone;
			if (loadInterval)
				interval <= `SDRAM_REFRESH_INTERVAL;
			else if (interval != 16'd0)
				interval <= interval - 16'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// refresh sequence
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state   <= SdramPkg::refIdle;
			gapLeft <= 4'd0;
		end else if (state == SdramPkg::refIdle) begin
			if (expired)
				state <= SdramPkg::refPrecharge;           // raises refReq
		end else if (refGrant) begin
			case (state)
				SdramPkg::refPrecharge: state <= SdramPkg::refNop;
				SdramPkg::refNop:       state <= SdramPkg::refAuto;
				SdramPkg::refAuto: begin
					gapLeft <= `SDRAM_REFRESH_GAP - 4'd1;
					state   <= SdramPkg::refGap;
				end
				default: begin                             // gap nops
					if (gapLeft != 4'd0)
						gapLeft <= gapLeft - 4'd1;
					else
						state <= SdramPkg::refIdle;        // drop refReq, reload timer
				end
			endcase
		end
	end

	always_comb begin
		refCmd  = `SDRAM_CMD_NOP;
		refAddr = 13'h0000;
		refBank = 2'b00;
		if (state == SdramPkg::refPrecharge) begin
			refCmd  = `SDRAM_CMD_PRECHARGE;
			refAddr = `SDRAM_PRECHARGE_ALL_ADDR;           // all banks
		end else if (state == SdramPkg::refAuto) begin
			refCmd  = `SDRAM_CMD_REFRESH;
		end
	end

endmodule

//--- source/CommandArbiter.sv
// Command arbiter: locks the SDRAM pins to one peer at a time and registers the chip pins
`include "SdramCtrl_defines.svh"

module CommandArbiter (
	input  logic                 Clock,
	input  logic                 Reset_L,
	input  logic                 initReq,
	input  SdramPkg::sdramCmd_t  initCmd,
	input  SdramPkg::rowAddr_t   initAddr,
	input  SdramPkg::bankAddr_t  initBank,
	input  logic                 refReq,
	input  SdramPkg::sdramCmd_t  refCmd,
	input  SdramPkg::rowAddr_t   refAddr,
	input  SdramPkg::bankAddr_t  refBank,
	output logic                 initGrant,
	output logic                 refGrant,
	output logic                 SDram_CKE_H,
	output logic                 SDram_CS_L,
	output logic                 SDram_RAS_L,
	output logic                 SDram_CAS_L,
	output logic                 SDram_WE_L,
	output SdramPkg::rowAddr_t   SDram_Addr,
	output SdramPkg::bankAddr_t  SDram_BA
);

	SdramPkg::sdramCmd_t   nextCmd;
	SdramPkg::rowAddr_t    nextAddr;
	SdramPkg::bankAddr_t   nextBank;
	logic                  anyGrant;
	logic                  everGranted;          // cleared only by reset

	assign anyGrant = initGrant || refGrant;

	//////////////////////////////////////////////////////////////////////
	// grant registers, fixed priority with lock
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			initGrant   <= 1'b0;
			refGrant    <= 1'b0;
			everGranted <= 1'b0;
		end else begin
			initGrant   <= initGrant ? initReq : (!anyGrant && initReq);  // sequencer wins
			refGrant    <= refGrant ? refReq : (!anyGrant && !initReq && refReq);
			everGranted <= everGranted || anyGrant;
		end
	end

	// pick the granted peer, else the idle default
	always_comb begin
		nextCmd  = everGranted ? `SDRAM_CMD_NOP : `SDRAM_CMD_POWERUP;
		nextAddr = 13'h0000;
		nextBank = 2'b00;
		if (initGrant && initReq) begin
			nextCmd  = initCmd;
			nextAddr = initAddr;
			nextBank = initBank;
		end else if (refGrant && refReq) begin
			nextCmd  = refCmd;
			nextAddr = refAddr;
			nextBank = refBank;
		end
	end

	// chip pin registers, one cycle after the grant
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			{SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} <= `SDRAM_CMD_POWERUP;
			SDram_Addr <= 13'h0000;
			SDram_BA   <= 2'b00;
		end else begin
			{SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} <= nextCmd;
			SDram_Addr <= nextAddr;
			SDram_BA   <= nextBank;
		end
	end

endmodule

//--- source/SdramCtrlTop.sv
// SDRAM controller top: power-up sequencer and refresh scheduler sharing pins through the arbiter
module SdramCtrlTop (
	input  logic                 Clock,
	input  logic                 Reset_L,
	output logic                 ResetOut_L,  // reset to the CPU
	output logic                 SDram_CKE_H,
	output logic                 SDram_CS_L,
	output logic                 SDram_RAS_L,
	output logic                 SDram_CAS_L,
	output logic                 SDram_WE_L,
	output SdramPkg::rowAddr_t   SDram_Addr,
	output SdramPkg::bankAddr_t  SDram_BA
);

	// sequencer side of the peer bus
	logic                 initReq;
	logic                 initGrant;
	logic                 initDone;
	SdramPkg::sdramCmd_t  initCmd;
	SdramPkg::rowAddr_t   initAddr;
	SdramPkg::bankAddr_t  initBank;

	// scheduler side of the peer bus
	logic                 refReq;
	logic                 refGrant;
	SdramPkg::sdramCmd_t  refCmd;
	SdramPkg::rowAddr_t   refAddr;
	SdramPkg::bankAddr_t  refBank;

	//////////////////////////////////////////////////////////////////////
	// command peers
	//////////////////////////////////////////////////////////////////////

	PowerUpSequencer powerUp (
		.Clock(Clock), .Reset_L(Reset_L), .initGrant(initGrant),
		.initReq(initReq), .initCmd(initCmd), .initAddr(initAddr), .initBank(initBank),
		.initDone(initDone), .ResetOut_L(ResetOut_L)
	);

	RefreshScheduler refresh (
		.Clock(Clock), .Reset_L(Reset_L), .initDone(initDone), .refGrant(refGrant),
		.refReq(refReq), .refCmd(refCmd), .refAddr(refAddr), .refBank(refBank)
	);

	//////////////////////////////////////////////////////////////////////
	// pin arbiter
	//////////////////////////////////////////////////////////////////////

	CommandArbiter arbiter (
		.Clock(Clock), .Reset_L(Reset_L),
		.initReq(initReq), .initCmd(initCmd), .initAddr(initAddr), .initBank(initBank),
		.refReq(refReq), .refCmd(refCmd), .refAddr(refAddr), .refBank(refBank),
		.initGrant(initGrant), .refGrant(refGrant),
		.SDram_CKE_H(SDram_CKE_H), .SDram_CS_L(SDram_CS_L), .SDram_RAS_L(SDram_RAS_L),
		.SDram_CAS_L(SDram_CAS_L), .SDram_WE_L(SDram_WE_L),
		.SDram_Addr(SDram_Addr), .SDram_BA(SDram_BA)
	);

endmodule

//--- verif/SdramCtrl_assert.sv
// SDRAM controller checks of the power-up pin states, init command order, refresh gaps and spacing
`include "SdramCtrl_defines.svh"

module SdramCtrlAssert (
	input logic                 Clock,
	input logic                 Reset_L,
	input logic                 ResetOut_L,
	input logic                 SDram_CKE_H,
	input logic                 SDram_CS_L,
	input logic                 SDram_RAS_L,
	input logic                 SDram_CAS_L,
	input logic                 SDram_WE_L,
	input SdramPkg::rowAddr_t   SDram_Addr,
	input SdramPkg::bankAddr_t  SDram_BA
);

	localparam SdramPkg::tickCount_t pinsLowCycles = `SDRAM_POWERUP_CYCLES + 16'd2;
	localparam SdramPkg::tickCount_t maxSpacing =
		`SDRAM_REFRESH_INTERVAL + 16'(`SDRAM_REFRESH_GAP) + 16'd6;

	SdramPkg::sdramCmd_t   cmd;                  // pins packed back into a command
	SdramPkg::tickCount_t  sinceReset;           // clocks since Reset_L released
	SdramPkg::tickCount_t  sinceRefresh;         // clocks since last run-mode refresh
	logic [3:0]            initRefreshes;        // refreshes before the mode load
	logic [3:0]            nopOwed;              // gap nops still due
	logic                  cmdSeen;              // a real command has gone out
	logic                  modeSeen;
	logic                  runRefreshSeen;
	logic                  isNop;
	logic                  isPrecharge;
	logic                  isRefresh;
	logic                  isModeSet;
	int unsigned           failCount = 0;        // read by the testbench

	assign cmd         = {SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L};
	assign isNop       = (cmd == `SDRAM_CMD_NOP);
	assign isPrecharge = (cmd == `SDRAM_CMD_PRECHARGE);
	assign isRefresh   = (cmd == `SDRAM_CMD_REFRESH);
	assign isModeSet   = (cmd == `SDRAM_CMD_MODESET);

	//////////////////////////////////////////////////////////////////////
	// history of the pins since reset
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			sinceReset     <= 16'd0;
			sinceRefresh   <= 16'd0;
			initRefreshes  <= 4'd0;
			nopOwed        <= 4'd0;
			cmdSeen        <= 1'b0;
			modeSeen       <= 1'b0;
			runRefreshSeen <= 1'b0;
		end else begin
			if (sinceReset != 16'hffff)
				sinceReset <= sinceReset + 16'd1;
			if (!isNop && cmd != `SDRAM_CMD_POWERUP)
				cmdSeen <= 1'b1;
			if (isRefresh && !modeSeen)
				initRefreshes <= initRefreshes + 4'd1;
			if (isModeSet)
				modeSeen <= 1'b1;
			if (isRefresh)
				nopOwed <= `SDRAM_REFRESH_GAP;       // gap starts next clock
			else if (nopOwed != 4'd0)
				nopOwed <= nopOwed - 4'd1;
			if (isRefresh && ResetOut_L) begin
				runRefreshSeen <= 1'b1;
				sinceRefresh   <= 16'd1;
			end else if (sinceRefresh != 16'hffff)
				sinceRefresh <= sinceRefresh + 16'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// power-up and initialisation
	//////////////////////////////////////////////////////////////////////

	assert property (@(posedge Clock)
		sinceReset < pinsLowCycles |-> !SDram_CKE_H && !SDram_CS_L && !ResetOut_L)
		else begin
			failCount++;
			$error("CKE, chip select or the CPU reset went high during the power-up wait");
		end

	// very first real command must close all banks
	assert property (@(posedge Clock)
		!cmdSeen && !isNop && cmd != `SDRAM_CMD_POWERUP |->
		isPrecharge && SDram_Addr == `SDRAM_PRECHARGE_ALL_ADDR)
		else begin
			failCount++;
			$error("MISMATCH time %0t first command %b SDram_Addr %h expected %b %h", $time,
				cmd, SDram_Addr, `SDRAM_CMD_PRECHARGE, `SDRAM_PRECHARGE_ALL_ADDR);
		end

	assert property (@(posedge Clock) isModeSet |-> !modeSeen)
		else begin
			failCount++;
			$error("a second mode-register load was issued after power-up");
		end

	assert property (@(posedge Clock) isModeSet |-> initRefreshes == `SDRAM_INIT_REFRESHES)
		else begin
			failCount++;
			$error("MISMATCH time %0t init refreshes %0d expected %0d", $time,
				initRefreshes, `SDRAM_INIT_REFRESHES);
		end

	assert property (@(posedge Clock)
		isModeSet |-> SDram_Addr == `SDRAM_MODE_VALUE && SDram_BA == 2'b00)
		else begin
			failCount++;
			$error("MISMATCH time %0t SDram_Addr %h SDram_BA %0d expected %h %0d", $time,
				SDram_Addr, SDram_BA, `SDRAM_MODE_VALUE, 2'b00);
		end

	assert property (@(posedge Clock) !modeSeen |-> !ResetOut_L)
		else begin
			failCount++;
			$error("CPU reset released before the mode-register load");
		end

	assert property (@(posedge Clock) sinceReset > 16'd3 && $past(isModeSet, 3) |-> ResetOut_L)
		else begin
			failCount++;
			$error("CPU reset still held 3 cycles after the mode-register load");
		end

	//////////////////////////////////////////////////////////////////////
	// refresh gaps and run mode
	//////////////////////////////////////////////////////////////////////

	assert property (@(posedge Clock) nopOwed != 4'd0 |-> isNop)
		else begin
			failCount++;
			$error("MISMATCH time %0t gap command %b expected %b", $time, cmd, `SDRAM_CMD_NOP);
		end

	assert property (@(posedge Clock) ResetOut_L && isRefresh |->
		$past(isPrecharge, 2) && $past(SDram_Addr, 2) == `SDRAM_PRECHARGE_ALL_ADDR)
		else begin
			failCount++;
			$error("run-mode auto-refresh was not preceded by a precharge of all banks");
		end

	assert property (@(posedge Clock)
		ResetOut_L |-> SDram_CKE_H && (isNop || isPrecharge || isRefresh))
		else begin
			failCount++;
			$error("MISMATCH time %0t run-mode command %b expected %b, %b or %b", $time,
				cmd, `SDRAM_CMD_NOP, `SDRAM_CMD_PRECHARGE, `SDRAM_CMD_REFRESH);
		end

	assert property (@(posedge Clock) ResetOut_L && isRefresh && runRefreshSeen |->
		sinceRefresh >= `SDRAM_REFRESH_INTERVAL)
		else begin
			failCount++;
			$error("MISMATCH time %0t refresh spacing %0d expected at least %0d", $time,
				sinceRefresh, `SDRAM_REFRESH_INTERVAL);
		end

	assert property (@(posedge Clock) ResetOut_L && runRefreshSeen |-> sinceRefresh <= maxSpacing)
		else begin
			failCount++;
			$error("no auto-refresh within %0d cycles of the previous one", maxSpacing);
		end

endmodule

bind SdramCtrlTop SdramCtrlAssert sdramChecks (
	.Clock(Clock), .Reset_L(Reset_L), .ResetOut_L(ResetOut_L),
	.SDram_CKE_H(SDram_CKE_H), .SDram_CS_L(SDram_CS_L), .SDram_RAS_L(SDram_RAS_L),
	.SDram_CAS_L(SDram_CAS_L), .SDram_WE_L(SDram_WE_L),
	.SDram_Addr(SDram_Addr), .SDram_BA(SDram_BA)
);

//--- verif/SdramCtrlTb.sv
// SDRAM controller testbench: power-up, run-mode refresh and a reset in the middle of run mode
`include "SdramCtrl_defines.svh"

module SdramCtrlTb;

	logic                 Clock;
	logic                 Reset_L;
	logic                 ResetOut_L;
	logic                 SDram_CKE_H;
	logic                 SDram_CS_L;
	logic                 SDram_RAS_L;
	logic                 SDram_CAS_L;
	logic                 SDram_WE_L;
	SdramPkg::rowAddr_t   SDram_Addr;
	SdramPkg::bankAddr_t  SDram_BA;

	int unsigned          testsRun;
	int unsigned          testsFailed;
	int unsigned          failsSeen;             // assertion failures charged so far
	logic                 stalled;               // last wait ran out of time

	SdramCtrlTop DUT (
		.Clock(Clock), .Reset_L(Reset_L), .ResetOut_L(ResetOut_L),
		.SDram_CKE_H(SDram_CKE_H), .SDram_CS_L(SDram_CS_L), .SDram_RAS_L(SDram_RAS_L),
		.SDram_CAS_L(SDram_CAS_L), .SDram_WE_L(SDram_WE_L),
		.SDram_Addr(SDram_Addr), .SDram_BA(SDram_BA)
	);

	always #5 Clock = ~Clock;                    // period 10

	//////////////////////////////////////////////////////////////////////
	// stimulus and waits
	//////////////////////////////////////////////////////////////////////

	// hold reset for 3 clocks, driven on rising edges
	task automatic applyReset();
		@(posedge Clock);
		Reset_L <= 1'b0;
		repeat (3) @(posedge Clock);
		Reset_L <= 1'b1;
	endtask

	task automatic waitCpuRelease(input int limit, output logic timedOut);
		int cycles;
		cycles = 0;
		do begin
			@(negedge Clock);                    // outputs settled mid cycle
			cycles++;
		end while (ResetOut_L !== 1'b1 && cycles < limit);
		timedOut = (ResetOut_L !== 1'b1);
		if (timedOut)
			$display("Timed out after %0d cycles waiting for the CPU reset release", limit);
	endtask

	task automatic waitRefreshes(input int count, input int limit, output logic timedOut);
		int cycles;
		int seen;
		cycles = 0;
		seen   = 0;
		while (seen < count && cycles < limit) begin
			@(negedge Clock);
			cycles++;
			if (ResetOut_L === 1'b1 && {SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L,
				SDram_WE_L} === `SDRAM_CMD_REFRESH)
				seen++;                          // one clock per refresh on the pins
		end
		timedOut = (seen < count);
		if (timedOut)
			$display("Timed out waiting for %0d run-mode refreshes, only %0d seen", count, seen);
	endtask

	// one result line per test
	task automatic finishTest(input string name, input logic timedOut);
		int unsigned newFails;
		newFails  = DUT.sdramChecks.failCount - failsSeen;
		failsSeen = DUT.sdramChecks.failCount;
		testsRun++;
		if (timedOut || newFails != 0) begin
			testsFailed++;
			$display("test %s failed, %0d assertion failures, timeout %0d", name, newFails,
				timedOut);
		end else
			$display("test %s passed", name);
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		Clock       = 1'b0;
		Reset_L     = 1'b0;
		testsRun    = 0;
		testsFailed = 0;
		failsSeen   = 0;

		applyReset();
		waitCpuRelease(100, stalled);            // init takes about 21 clocks
		finishTest("power-up sequence", stalled);

		waitRefreshes(3, 400, stalled);
		finishTest("run-mode refresh", stalled);

		applyReset();                            // lands in the gap after a refresh
		waitCpuRelease(100, stalled);
		finishTest("mid-run reset", stalled);

		waitRefreshes(1, 200, stalled);
		finishTest("refresh after re-init", stalled);

		$display("tests run %0d, tests failed %0d, assertion failures %0d", testsRun,
			testsFailed, DUT.sdramChecks.failCount);
		if (testsFailed == 0 && DUT.sdramChecks.failCount == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- sim.f
+incdir+source
source/SdramPkg.sv
source/PowerUpSequencer.sv
source/RefreshScheduler.sv
source/CommandArbiter.sv
source/SdramCtrlTop.sv
verif/SdramCtrl_assert.sv
verif/SdramCtrlTb.sv

//--- Makefile
# Verilator build and run of the SDRAM controller testbench
VERILATOR  ?= verilator
TOP        := SdramCtrlTb
FILELIST   := sim.f
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert -Wall
BUILD      := obj_dir
LOG        := sim.log
RUN_ARGS   := +verilator+error+limit+1000
FAIL_MSG   := ** FAIL **
PASS_MSG   := ** PASS **
SOURCES    := $(wildcard source/*.sv source/*.svh verif/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	-./$(BUILD)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
